//--- files.f
rtl/stk_pkg.sv
+incdir+include
rtl/stk_cmd_arb.sv
rtl/stk_pipe_lk.sv
rtl/stk_pipe_al.sv
rtl/stk_pipe_mem.sv
rtl/stk.sv
tests/tb_stk.sv

//--- rtl/stk.sv
// Multi-stack engine top level, ENGS_N stacks over one shared pool.
// Commands are accepted after the ENTRIES_N cycle free-list build.
// Response follows two cycles after the acknowledge, never stalls.
// Arbiter, lookup with allocation, then storage with response register.
`timescale 1ns/1ps

module stk #(
  parameter int ENGS_N    = 4,
  parameter int ENTRIES_N = 16,
  parameter int DATA_W    = 128
) (
  input  logic                                clk,
  input  logic                                i_arst_n,
  input  logic [ENGS_N-1:0]                   i_cmd_vld,
  input  stk_pkg::opcode_t [ENGS_N-1:0]       i_cmd_opcode,
  input  logic [ENGS_N-1:0][DATA_W-1:0]       i_cmd_dat,
  output logic [ENGS_N-1:0]                   o_cmd_ack,
  output logic [ENGS_N-1:0]                   o_rsp_vld,
  output logic [DATA_W-1:0]                   o_rsp_dat,
  output stk_pkg::status_t                    o_rsp_status
);

  import stk_pkg::*;

  localparam int ENG_W = $clog2(ENGS_N);
  localparam int PTR_W = $clog2(ENTRIES_N);

  // Stage 1, arbiter to lookup
  logic              s1_vld;
  logic [ENG_W-1:0]  s1_engid;
  opcode_t           s1_opcode;
  logic [DATA_W-1:0] s1_dat;
  logic              al_busy;

  // Lookup and allocation, same cycle
  logic              lk_push_go;
  logic              lk_pop_go;
  logic [PTR_W-1:0]  lk_head;
  logic [PTR_W-1:0]  al_free_ptr;
  logic              al_full;
  logic [PTR_W-1:0]  al_next;

  // Stage 2, into storage
  logic              s2_vld;
  logic [ENG_W-1:0]  s2_engid;
  opcode_t           s2_opcode;
  status_t           s2_status;
  logic              s2_wr;
  logic [PTR_W-1:0]  s2_ptr;
  logic [DATA_W-1:0] s2_dat;

  stk_cmd_arb #(.ENGS_N(ENGS_N), .DATA_W(DATA_W)) u_arb (
    .clk, .i_arst_n, .i_cmd_vld, .i_cmd_opcode, .i_cmd_dat,
    .i_al_busy   (al_busy),
    .o_cmd_ack,
    .o_s1_vld    (s1_vld),
    .o_s1_engid  (s1_engid),
    .o_s1_opcode (s1_opcode),
    .o_s1_dat    (s1_dat)
  );

  stk_pipe_lk #(.ENGS_N(ENGS_N), .ENTRIES_N(ENTRIES_N), .DATA_W(DATA_W)) u_lk (
    .clk, .i_arst_n,
    .i_s1_vld (s1_vld), .i_s1_engid (s1_engid), .i_s1_opcode (s1_opcode),
    .i_s1_dat (s1_dat),
    .i_al_free_ptr (al_free_ptr), .i_al_full (al_full), .i_al_next (al_next),
    .o_push_go (lk_push_go), .o_pop_go (lk_pop_go), .o_head (lk_head),
    .o_s2_vld (s2_vld), .o_s2_engid (s2_engid), .o_s2_opcode (s2_opcode),
    .o_s2_status (s2_status), .o_s2_wr (s2_wr), .o_s2_ptr (s2_ptr),
    .o_s2_dat (s2_dat)
  );

  stk_pipe_al #(.ENTRIES_N(ENTRIES_N)) u_al (
    .clk, .i_arst_n,
    .i_push_go (lk_push_go), .i_pop_go (lk_pop_go), .i_head (lk_head),
    .o_free_ptr (al_free_ptr), .o_full (al_full), .o_next (al_next),
    .o_busy (al_busy)
  );

  stk_pipe_mem #(.ENGS_N(ENGS_N), .ENTRIES_N(ENTRIES_N), .DATA_W(DATA_W)) u_mem (
    .clk, .i_arst_n,
    .i_s2_vld (s2_vld), .i_s2_engid (s2_engid), .i_s2_opcode (s2_opcode),
    .i_s2_status (s2_status), .i_s2_wr (s2_wr), .i_s2_ptr (s2_ptr),
    .i_s2_dat (s2_dat),
    .o_rsp_vld, .o_rsp_dat, .o_rsp_status
  );

endmodule

//--- rtl/stk_cmd_arb.sv
// Round-robin command arbiter, one accepted command per cycle.
// The acknowledge is registered and leaves together with stage 1.
// A port whose acknowledge is high this cycle is not granted again,
// since its valid is still seen until the requester reacts.
// No grant is given while the allocation stage builds the free list.
`timescale 1ns/1ps

module stk_cmd_arb #(
  parameter int ENGS_N = 4,
  parameter int DATA_W = 128,
  localparam int ENG_W = $clog2(ENGS_N)
) (
  input  logic                                clk,
  input  logic                                i_arst_n,
  input  logic [ENGS_N-1:0]                   i_cmd_vld,
  input  stk_pkg::opcode_t [ENGS_N-1:0]       i_cmd_opcode,
  input  logic [ENGS_N-1:0][DATA_W-1:0]       i_cmd_dat,
  input  logic                                i_al_busy,
  output logic [ENGS_N-1:0]                   o_cmd_ack,
  output logic                                o_s1_vld,
  output logic [ENG_W-1:0]                    o_s1_engid,
  output stk_pkg::opcode_t                    o_s1_opcode,
  output logic [DATA_W-1:0]                   o_s1_dat
);

  // Requests still eligible this cycle
  logic [ENGS_N-1:0] req;
  // Port granted last, search starts just after it
  logic [ENG_W-1:0]  last_r;
  logic              gnt_vld;
  logic [ENG_W-1:0]  gnt_idx;
  logic [ENGS_N-1:0] gnt_vec;

  // Mask the port being acknowledged now and hold off during list build
  assign req = i_al_busy ? '0 : (i_cmd_vld & ~o_cmd_ack);

  // Rotating priority search
  always_comb begin
    int idx;
    gnt_vld = 1'b0;
    gnt_idx = '0;
    gnt_vec = '0;
    for (int i = 1; i <= ENGS_N; i++) begin
      idx = (int'(last_r) + i) % ENGS_N;
      if (!gnt_vld && req[idx]) begin
        gnt_vld      = 1'b1;
        gnt_idx      = ENG_W'(idx);
        gnt_vec[idx] = 1'b1;
      end
    end
  end

  // Control state, acknowledge and stage 1 valid
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      // Port 0 wins the first round
      last_r    <= ENG_W'(ENGS_N - 1);
      o_cmd_ack <= '0;
      o_s1_vld  <= 1'b0;
    end else begin
      o_cmd_ack <= gnt_vec;
      o_s1_vld  <= gnt_vld;
      if (gnt_vld) begin
        last_r <= gnt_idx;
      end
    end
  end

  // Stage 1 payload, captured from the winning port
  always_ff @(posedge clk) begin
    if (gnt_vld) begin
      o_s1_engid  <= gnt_idx;
      o_s1_opcode <= i_cmd_opcode[gnt_idx];
      o_s1_dat    <= i_cmd_dat[gnt_idx];
    end
  end

endmodule

//--- rtl/stk_pipe_al.sv
// Allocation stage, one next-pointer array for the free list and all stacks.
// After reset the free list is built one entry per cycle, busy meanwhile,
// for exactly ENTRIES_N cycles. The last entry links back to entry 0;
// that link is never followed because the full flag stops pushes first.
// At most one of push and pop is asserted in a cycle.
`timescale 1ns/1ps

module stk_pipe_al #(
  parameter int ENTRIES_N = 16,
  localparam int PTR_W    = $clog2(ENTRIES_N)
) (
  input  logic               clk,
  input  logic               i_arst_n,
  input  logic               i_push_go,
  input  logic               i_pop_go,
  input  logic [PTR_W-1:0]   i_head,
  output logic [PTR_W-1:0]   o_free_ptr,
  output logic               o_full,
  output logic [PTR_W-1:0]   o_next,
  output logic               o_busy
);

  // Link of each entry, towards the bottom of its list
  logic [PTR_W-1:0] next_r [ENTRIES_N];
  logic [PTR_W-1:0] free_head_r;
  // Entries held by the stacks
  logic [PTR_W:0]   count_r;
  logic             busy_r;
  logic [PTR_W-1:0] init_idx_r;

  // Single write port on the link array
  logic             nxt_we;
  logic [PTR_W-1:0] nxt_wa;
  logic [PTR_W-1:0] nxt_wd;

  assign o_free_ptr = free_head_r;
  assign o_next     = next_r[i_head];
  assign o_full     = (count_r == (PTR_W + 1)'(ENTRIES_N));
  assign o_busy     = busy_r;

  // Link write select
  always_comb begin
    nxt_we = 1'b0;
    nxt_wa = init_idx_r;
    nxt_wd = init_idx_r + 1'b1;
    if (busy_r) begin
      // Build, entry k points at k+1
      nxt_we = 1'b1;
    end else if (i_push_go) begin
      // Taken entry sits on the old stack top
      nxt_we = 1'b1;
      nxt_wa = free_head_r;
      nxt_wd = i_head;
    end else if (i_pop_go) begin
      // Popped entry goes in front of the free list
      nxt_we = 1'b1;
      nxt_wa = i_head;
      nxt_wd = free_head_r;
    end
  end

  always_ff @(posedge clk) begin
    if (nxt_we) begin
      next_r[nxt_wa] <= nxt_wd;
    end
  end

  // Build sequencer
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy_r     <= 1'b1;
      init_idx_r <= '0;
    end else if (busy_r) begin
      init_idx_r <= init_idx_r + 1'b1;
      if (init_idx_r == PTR_W'(ENTRIES_N - 1)) begin
        busy_r <= 1'b0;
      end
    end
  end

  // Free-list head and occupancy
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      free_head_r <= '0;
      count_r     <= '0;
    end else if (i_push_go) begin
      free_head_r <= next_r[free_head_r];
      count_r     <= count_r + 1'b1;
    end else if (i_pop_go) begin
      free_head_r <= i_head;
      count_r     <= count_r - 1'b1;
    end
  end

endmodule

//--- rtl/stk_pipe_lk.sv
// Lookup stage, per-stack head and tail pointers plus empty flags.
// Decides the command outcome in the cycle stage 1 is valid and updates
// its tables at the same edge, so a following command sees the new state.
// Head and tail are meaningful only while the stack is not empty.
`timescale 1ns/1ps

module stk_pipe_lk #(
  parameter int ENGS_N    = 4,
  parameter int ENTRIES_N = 16,
  parameter int DATA_W    = 128,
  localparam int ENG_W    = $clog2(ENGS_N),
  localparam int PTR_W    = $clog2(ENTRIES_N)
) (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_s1_vld,
  input  logic [ENG_W-1:0]     i_s1_engid,
  input  stk_pkg::opcode_t     i_s1_opcode,
  input  logic [DATA_W-1:0]    i_s1_dat,
  input  logic [PTR_W-1:0]     i_al_free_ptr,
  input  logic                 i_al_full,
  input  logic [PTR_W-1:0]     i_al_next,
  output logic                 o_push_go,
  output logic                 o_pop_go,
  output logic [PTR_W-1:0]     o_head,
  output logic                 o_s2_vld,
  output logic [ENG_W-1:0]     o_s2_engid,
  output stk_pkg::opcode_t     o_s2_opcode,
  output stk_pkg::status_t     o_s2_status,
  output logic                 o_s2_wr,
  output logic [PTR_W-1:0]     o_s2_ptr,
  output logic [DATA_W-1:0]    o_s2_dat
);

  import stk_pkg::*;

  // Top entry of each stack
  logic [PTR_W-1:0] head_r [ENGS_N];
  // Bottom entry, head equal to tail means one entry left
  logic [PTR_W-1:0] tail_r [ENGS_N];
  logic [ENGS_N-1:0] empty_r;
  status_t           status;

  // Outcome, reserved code first, then stack state, then pool state
  always_comb begin
    status = ST_OKAY;
    if (op_is_rsvd(i_s1_opcode)) begin
      status = ST_BAD_OP;
    end else if (op_reads_data(i_s1_opcode) && empty_r[i_s1_engid]) begin
      status = ST_EMPTY;
    end else if (op_takes_entry(i_s1_opcode) && i_al_full) begin
      status = ST_FULL;
    end
  end

  assign o_push_go = i_s1_vld && (status == ST_OKAY) && op_takes_entry(i_s1_opcode);
  assign o_pop_go  = i_s1_vld && (status == ST_OKAY) && op_frees_entry(i_s1_opcode);
  assign o_head    = head_r[i_s1_engid];

  // Stack tables
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int e = 0; e < ENGS_N; e++) begin
        head_r[e] <= '0;
        tail_r[e] <= '0;
      end
      empty_r <= '1;
    end else if (o_push_go) begin
      // New top is the entry just taken from the free list
      head_r[i_s1_engid]  <= i_al_free_ptr;
      empty_r[i_s1_engid] <= 1'b0;
      if (empty_r[i_s1_engid]) begin
        tail_r[i_s1_engid] <= i_al_free_ptr;
      end
    end else if (o_pop_go) begin
      head_r[i_s1_engid] <= i_al_next;
      if (head_r[i_s1_engid] == tail_r[i_s1_engid]) begin
        empty_r[i_s1_engid] <= 1'b1;
      end
    end
  end

  // Stage 2 valid
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_s2_vld <= 1'b0;
    end else begin
      o_s2_vld <= i_s1_vld;
    end
  end

  // Stage 2 payload, push writes the new entry, reads use the current top
  always_ff @(posedge clk) begin
    if (i_s1_vld) begin
      o_s2_engid  <= i_s1_engid;
      o_s2_opcode <= i_s1_opcode;
      o_s2_status <= status;
      o_s2_wr     <= o_push_go;
      o_s2_ptr    <= op_takes_entry(i_s1_opcode) ? i_al_free_ptr : head_r[i_s1_engid];
      o_s2_dat    <= i_s1_dat;
    end
  end

endmodule

//--- rtl/stk_pipe_mem.sv
// Storage stage, ENTRIES_N data words and the response register.
// Write on a successful push, read on a successful pop or peek.
// Response valid is one-hot by port and lasts one cycle, no stall.
// Response data is zero unless the command returned a stored word.
`timescale 1ns/1ps

module stk_pipe_mem #(
  parameter int ENGS_N    = 4,
  parameter int ENTRIES_N = 16,
  parameter int DATA_W    = 128,
  localparam int ENG_W    = $clog2(ENGS_N),
  localparam int PTR_W    = $clog2(ENTRIES_N)
) (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_s2_vld,
  input  logic [ENG_W-1:0]     i_s2_engid,
  input  stk_pkg::opcode_t     i_s2_opcode,
  input  stk_pkg::status_t     i_s2_status,
  input  logic                 i_s2_wr,
  input  logic [PTR_W-1:0]     i_s2_ptr,
  input  logic [DATA_W-1:0]    i_s2_dat,
  output logic [ENGS_N-1:0]    o_rsp_vld,
  output logic [DATA_W-1:0]    o_rsp_dat,
  output stk_pkg::status_t     o_rsp_status
);

  import stk_pkg::*;

  logic [DATA_W-1:0] mem_r [ENTRIES_N];
  logic              rd_ok;
  logic [ENGS_N-1:0] rsp_sel;

  // Word goes out only for a pop or peek that succeeded
  assign rd_ok = (i_s2_status == ST_OKAY) && op_reads_data(i_s2_opcode);

  // Port number to one-hot valid
  always_comb begin
    rsp_sel = '0;
    rsp_sel[i_s2_engid] = i_s2_vld;
  end

  // Data array
  always_ff @(posedge clk) begin
    if (i_s2_vld && i_s2_wr) begin
      mem_r[i_s2_ptr] <= i_s2_dat;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rsp_vld <= '0;
    end else begin
      o_rsp_vld <= rsp_sel;
    end
  end

  // Response payload
  always_ff @(posedge clk) begin
    if (i_s2_vld) begin
      o_rsp_status <= i_s2_status;
      o_rsp_dat    <= rd_ok ? mem_r[i_s2_ptr] : '0;
    end
  end

endmodule

//--- rtl/stk_pkg.sv
// Shared opcode and status encodings for the multi-stack engine.
// Opcode 3 is reserved and always answered with BAD_OP.
// Helpers only decode the opcode; outcome also depends on stack and pool state.
package stk_pkg;

  // Command codes, as driven on each command port
  typedef enum logic [1:0] {
    OP_PUSH = 2'd0,
    OP_POP  = 2'd1,
    OP_PEEK = 2'd2,
    OP_RSVD = 2'd3
  } opcode_t;

  // Result codes returned on the response bus
  typedef enum logic [1:0] {
    ST_OKAY   = 2'd0,
    // Push refused, every pool entry is in use
    ST_FULL   = 2'd1,
    // Pop or peek with nothing on the stack
    ST_EMPTY  = 2'd2,
    ST_BAD_OP = 2'd3
  } status_t;

  // Command consumes one entry from the free list
  function automatic logic op_takes_entry(opcode_t op);
    return op == OP_PUSH;
  endfunction

  // Command hands the stack top back to the free list
  function automatic logic op_frees_entry(opcode_t op);
    return op == OP_POP;
  endfunction

  // Command returns the stored word of the stack top
  function automatic logic op_reads_data(opcode_t op);
    return (op == OP_POP) || (op == OP_PEEK);
  endfunction

  // Reserved code, no state is touched
  function automatic logic op_is_rsvd(opcode_t op);
    return op == OP_RSVD;
  endfunction

endpackage

//--- include/tb_stk_model.svh
// Reference model for the stack engine testbench, included inside tb_stk.
// ENGS_N, ENTRIES_N, DATA_W, DRV_DLY, clk and the command signals must be
// declared before the include. Callers of issue start DRV_DLY after a rising
// edge and get control back at the same point of a later cycle.
`ifndef TB_STK_MODEL_SVH
`define TB_STK_MODEL_SVH

// Model stacks, one row per port, index 0 is the bottom
logic [DATA_W-1:0] mdl_stk [ENGS_N][ENTRIES_N];
int                mdl_depth [ENGS_N] = '{default: 0};
// Entries held over all ports, the shared pool
int                mdl_occ = 0;

// Responses still due, in acknowledge order
int                exp_due  [$];
int                exp_port [$];
logic [1:0]        exp_st   [$];
logic [DATA_W-1:0] exp_dat  [$];

// Apply one acknowledged command to the model and queue its response
task automatic predict(input int p, input opcode_t op, input logic [DATA_W-1:0] d,
                       input int due);
  status_t           st;
  logic [DATA_W-1:0] rd;
  st = ST_OKAY;
  rd = '0;
  if (op == OP_RSVD) begin
    st = ST_BAD_OP;
  end else if (op != OP_PUSH && mdl_depth[p] == 0) begin
    st = ST_EMPTY;
  end else if (op == OP_PUSH && mdl_occ == ENTRIES_N) begin
    st = ST_FULL;
  end else if (op == OP_PUSH) begin
    mdl_stk[p][mdl_depth[p]] = d;
    mdl_depth[p]++;
    mdl_occ++;
  end else begin
    // Pop and peek both return the top word
    rd = mdl_stk[p][mdl_depth[p] - 1];
    if (op == OP_POP) begin
      mdl_depth[p]--;
      mdl_occ--;
    end
  end
  exp_due.push_back(due);
  exp_port.push_back(p);
  exp_st.push_back(st);
  exp_dat.push_back(rd);
endtask

// Hold one command on port p until its acknowledge is seen
task automatic issue(input int p, input opcode_t op, input logic [DATA_W-1:0] d);
  cmd_opcode[p] = op;
  cmd_dat[p]    = d;
  cmd_vld[p]    = 1'b1;
  @(negedge clk);
  while (!cmd_ack[p]) begin
    @(negedge clk);
  end
  // Drop the request after the edge that masks this port
  @(posedge clk);
  #DRV_DLY;
  cmd_vld[p] = 1'b0;
endtask

`endif

//--- tests/tb_stk.sv
// Testbench for the multi-stack engine, default parameters only.
// Inputs change 1 ns after the rising edge, all checks run at the falling edge.
// Responses are expected two cycles after the acknowledge, in acknowledge order.
`timescale 1ns/1ps

module tb_stk;

  import stk_pkg::*;

  localparam int ENGS_N      = 4;
  localparam int ENTRIES_N   = 16;
  localparam int DATA_W      = 128;
  localparam int DRV_DLY     = 1;
  // Roughly 110 commands are issued over all tests
  localparam int N_CMDS      = 120;
  localparam int TIMEOUT_CYC = N_CMDS * ENGS_N + ENTRIES_N + 200;

  logic                          clk;
  logic                          i_arst_n;
  logic [ENGS_N-1:0]             cmd_vld;
  opcode_t [ENGS_N-1:0]          cmd_opcode;
  logic [ENGS_N-1:0][DATA_W-1:0] cmd_dat;
  logic [ENGS_N-1:0]             cmd_ack;
  logic [ENGS_N-1:0]             rsp_vld;
  logic [DATA_W-1:0]             rsp_dat;
  status_t                       rsp_status;

  int                err_cnt  = 0;
  int                chk_cnt  = 0;
  // Rising edges since reset release
  int                edge_cnt = 0;
  // Request and acknowledge as the arbiter saw them at the last edge
  logic [ENGS_N-1:0] prev_vld = '0;
  logic [ENGS_N-1:0] prev_ack = '0;
  // Grants to other ports while a port is pending
  int                wait_cnt [ENGS_N] = '{default: 0};
  bit                first_ack_seen = 1'b0;

  `include "tb_stk_model.svh"

  stk #(.ENGS_N(ENGS_N), .ENTRIES_N(ENTRIES_N), .DATA_W(DATA_W)) i_dut (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_cmd_vld    (cmd_vld),
    .i_cmd_opcode (cmd_opcode),
    .i_cmd_dat    (cmd_dat),
    .o_cmd_ack    (cmd_ack),
    .o_rsp_vld    (rsp_vld),
    .o_rsp_dat    (rsp_dat),
    .o_rsp_status (rsp_status)
  );

  always #20 clk = ~clk;

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    for (int i = 0; i < DATA_W / 32; i++) begin
      w[i*32 +: 32] = $urandom;
    end
    return w;
  endfunction

  task automatic check_val(input string name, input logic [DATA_W-1:0] exp_v,
                           input logic [DATA_W-1:0] got_v);
    chk_cnt++;
    assert (got_v === exp_v) else begin
      err_cnt++;
      $display("CHECK FAILED %s expected 0x%0h got 0x%0h at %0t", name, exp_v, got_v, $time);
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
  endtask

  task automatic push_burst(input int p, input int n);
    for (int i = 0; i < n; i++) begin
      issue(p, OP_PUSH, rand_word());
    end
  endtask

  task automatic pop_burst(input int p, input int n);
    for (int i = 0; i < n; i++) begin
      issue(p, OP_POP, '0);
    end
  endtask

  // Random mix including the reserved code
  task automatic rand_cmds(input int p, input int n);
    opcode_t op;
    for (int i = 0; i < n; i++) begin
      op = opcode_t'($urandom_range(3, 0));
      issue(p, op, rand_word());
    end
  endtask

  // Response, acknowledge and fairness checks
  always @(negedge clk) begin
    int q;
    if (exp_due.size() != 0 && exp_due[0] == edge_cnt) begin
      if (rsp_vld == '0) begin
        err_cnt++;
        $display("ERROR: no response for port %0d at cycle %0d", exp_port[0], edge_cnt);
      end else begin
        check_val("o_rsp_vld", 1 << exp_port[0], rsp_vld);
        check_val("o_rsp_status", exp_st[0], rsp_status);
        check_val("o_rsp_dat", exp_dat[0], rsp_dat);
      end
      void'(exp_due.pop_front());
      void'(exp_port.pop_front());
      void'(exp_st.pop_front());
      void'(exp_dat.pop_front());
    end else if (rsp_vld != '0) begin
      err_cnt++;
      $display("ERROR: response on ports 0x%0h with no command due", rsp_vld);
    end
    check_val("o_cmd_ack onehot", 1, $onehot0(cmd_ack));
    if (cmd_ack != '0) begin
      q = 0;
      for (int i = 0; i < ENGS_N; i++) begin
        if (cmd_ack[i]) q = i;
      end
      // Build takes ENTRIES_N cycles, then one cycle to register the grant
      if (!first_ack_seen) begin
        first_ack_seen = 1'b1;
        check_val("first_ack_cycle", ENTRIES_N + 1, edge_cnt);
      end
      if (!(prev_vld[q] && !prev_ack[q])) begin
        err_cnt++;
        $display("ERROR: acknowledge on port %0d without a pending request", q);
      end
      for (int i = 0; i < ENGS_N; i++) begin
        if (i != q && prev_vld[i] && !prev_ack[i]) begin
          wait_cnt[i]++;
          assert (wait_cnt[i] < ENGS_N) else begin
            err_cnt++;
            $display("ERROR: port %0d passed over by %0d grants in a row", i, wait_cnt[i]);
          end
        end
      end
      wait_cnt[q] = 0;
      predict(q, cmd_opcode[q], cmd_dat[q], edge_cnt + 2);
    end
    prev_vld = cmd_vld;
    prev_ack = cmd_ack;
  end

  // Cycle count and timeout
  always @(posedge clk) begin
    if (i_arst_n) begin
      edge_cnt++;
    end
    if (edge_cnt > TIMEOUT_CYC) begin
      $display("ERROR: timeout after %0d cycles with commands or responses pending", edge_cnt);
      print_summary();
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    clk      = 1'b0;
    i_arst_n = 1'b1;
    cmd_vld  = '0;
    cmd_dat  = '0;
    for (int i = 0; i < ENGS_N; i++) begin
      cmd_opcode[i] = OP_PUSH;
    end
    void'($urandom(52636));
    #DRV_DLY;
    i_arst_n = 1'b0;
    repeat (5) @(posedge clk);
    #DRV_DLY;
    i_arst_n = 1'b1;

    // Held from release, must wait out the free-list build
    issue(0, OP_PEEK, '0);

    // Stack order and peek on port 1
    push_burst(1, 5);
    issue(1, OP_PEEK, '0);
    pop_burst(1, 5);

    // Empty stack and reserved code on port 2
    issue(2, OP_POP, '0);
    issue(2, OP_PEEK, '0);
    issue(2, OP_RSVD, rand_word());
    issue(2, OP_PUSH, rand_word());
    issue(2, OP_RSVD, rand_word());
    issue(2, OP_PEEK, '0);
    pop_burst(2, 2);

    // Fill the shared pool from all ports, then one pop frees a slot
    fork
      push_burst(0, 4);
      push_burst(1, 4);
      push_burst(2, 4);
      push_burst(3, 4);
    join
    issue(3, OP_PUSH, rand_word());
    issue(0, OP_POP, '0);
    issue(2, OP_PUSH, rand_word());
    issue(1, OP_PUSH, rand_word());
    fork
      pop_burst(0, 5);
      pop_burst(1, 5);
      pop_burst(2, 5);
      pop_burst(3, 5);
    join

    // All ports requesting back to back
    fork
      rand_cmds(0, 12);
      rand_cmds(1, 12);
      rand_cmds(2, 12);
      rand_cmds(3, 12);
    join

    while (exp_due.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    print_summary();
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
